/* src/pcie_core_pkg.sv */
// Shared types and constants for the PCIe completer core.
// Request, decoded op and completion payloads travel as single packed structs.

package pcie_core_pkg;

    // request field widths
    localparam int BAR_NUM_W = 3;
    localparam int DW_ADDR_W = 8;
    localparam int TAG_W     = 8;
    localparam int DATA_W    = 32;
    localparam int BE_W      = DATA_W / 8;

    // BAR0 register aperture
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = 4;

    localparam logic [REG_IDX_W-1:0] IDX_ID       = 4'd0;
    localparam logic [REG_IDX_W-1:0] IDX_CTRL     = 4'd1;
    localparam logic [REG_IDX_W-1:0] IDX_REQ_CNT  = 4'd2;
    localparam logic [REG_IDX_W-1:0] IDX_SCRATCH0 = 4'd3;

    // control register bits
    localparam int CTRL_LED_G    = 0;
    localparam int CTRL_ERR_CLR  = 1;
    localparam int CTRL_ERR_STAT = 2;

    // activity LED hold time in idle cycles
    localparam int ACT_HOLD  = 64;
    localparam int ACT_CNT_W = $clog2(ACT_HOLD + 1);

    localparam logic [DATA_W-1:0] CORE_ID = 32'h5043_0a01;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_UR_READ,
        OP_DROP
    } op_kind_t;

    typedef enum logic [2:0] {
        CPL_SC = 3'd0,
        CPL_UR = 3'd1
    } cpl_status_t;

    typedef struct packed {
        logic                 is_write;
        logic [BAR_NUM_W-1:0] bar;
        logic [DW_ADDR_W-1:0] dw_addr;
        logic [TAG_W-1:0]     tag;
        logic [BE_W-1:0]      byte_en;
        logic [DATA_W-1:0]    data;
    } cq_req_t;

    typedef struct packed {
        op_kind_t             kind;
        logic [REG_IDX_W-1:0] index;
        logic [BE_W-1:0]      byte_en;
        logic [DATA_W-1:0]    data;
        logic [TAG_W-1:0]     tag;
    } reg_op_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        cpl_status_t       status;
        logic [DATA_W-1:0] data;
    } cc_cpl_t;

endpackage

/* src/skid_buffer.sv */
// Two-entry register slice for valid/ready streams of any payload type.
// Ready comes from a register, throughput stays at one transfer per cycle.

`timescale 1ns/1ps

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     main_valid;
    logic     skid_valid;
    payload_t main_data;
    payload_t skid_data;
    logic     main_load;

    // main entry is free or drains this cycle
    assign main_load = !main_valid || out_ready;

    // only blocked once the skid entry holds an item
    assign in_ready = !skid_valid;

    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // skid entry goes first to keep order
            main_valid <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_load && in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

/* src/cq_decoder.sv */
// Decodes completer requests against the BAR0 register aperture.
// Produces one register op per request, flags write misses as uncorrectable errors.

`timescale 1ns/1ps

module cq_decoder (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  pcie_core_pkg::cq_req_t in_req,

    output logic                   op_valid,
    input  logic                   op_ready,
    output pcie_core_pkg::reg_op_t op,

    output logic                   req_accept,
    output logic                   status_error_uncor
);

    import pcie_core_pkg::*;

    logic    in_fire;
    logic    hit;
    reg_op_t next_op;

    // output register frees up when empty or when its op is taken
    assign in_ready = !op_valid || op_ready;
    assign in_fire  = in_valid && in_ready;

    assign hit = (in_req.bar == '0) && (in_req.dw_addr < DW_ADDR_W'(REG_COUNT));

    always_comb begin
        next_op.index   = in_req.dw_addr[REG_IDX_W-1:0];
        next_op.byte_en = in_req.byte_en;
        next_op.data    = in_req.data;
        next_op.tag     = in_req.tag;

        if (hit) begin
            next_op.kind = in_req.is_write ? OP_WRITE : OP_READ;
        end else begin
            // reads still owe a completion, writes are dropped
            next_op.kind = in_req.is_write ? OP_DROP : OP_UR_READ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid           <= 1'b0;
            req_accept         <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            if (in_ready) begin
                op_valid <= in_valid;
            end
            req_accept         <= in_fire;
            status_error_uncor <= in_fire && in_req.is_write && !hit;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            op <= next_op;
        end
    end

endmodule

/* src/bar_regfile.sv */
// BAR0 register file with identifier, control, request counter and scratch registers.
// Executes decoded ops and returns one completion per read, in order.

`timescale 1ns/1ps

module bar_regfile (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   op_valid,
    output logic                   op_ready,
    input  pcie_core_pkg::reg_op_t op,

    input  logic                   error_pulse,

    output logic                   cpl_valid,
    input  logic                   cpl_ready,
    output pcie_core_pkg::cc_cpl_t cpl,

    output logic                   led_stat_g,
    output logic                   led_stat_y
);

    import pcie_core_pkg::*;

    logic              led_g_en;
    logic              err_flag;
    logic [DATA_W-1:0] req_count;
    logic [DATA_W-1:0] scratch [IDX_SCRATCH0:REG_COUNT-1];

    logic              op_fire;
    logic              exec_write;
    logic              exec_read;
    logic              cpl_load;
    logic [DATA_W-1:0] ctrl_rd;
    logic [DATA_W-1:0] rd_data;

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // stalls only while a completion waits downstream
    assign op_ready   = !cpl_valid || cpl_ready;
    assign op_fire    = op_valid && op_ready;
    assign exec_write = op_fire && (op.kind == OP_WRITE);
    assign exec_read  = op_fire && (op.kind == OP_READ);
    assign cpl_load   = exec_read || (op_fire && (op.kind == OP_UR_READ));

    always_comb begin
        ctrl_rd                = '0;
        ctrl_rd[CTRL_LED_G]    = led_g_en;
        ctrl_rd[CTRL_ERR_STAT] = err_flag;
    end

    always_comb begin
        case (op.index)
            IDX_ID:      rd_data = CORE_ID;
            IDX_CTRL:    rd_data = ctrl_rd;
            IDX_REQ_CNT: rd_data = req_count;
            default:     rd_data = scratch[op.index];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            led_g_en  <= 1'b0;
            err_flag  <= 1'b0;
            req_count <= '0;
            for (int i = IDX_SCRATCH0; i < REG_COUNT; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            // reads see the count from before their own hit
            if (exec_read || exec_write) begin
                req_count <= req_count + 1'b1;
            end

            if (exec_write && op.index == IDX_CTRL && op.byte_en[0]) begin
                led_g_en <= op.data[CTRL_LED_G];
                if (op.data[CTRL_ERR_CLR]) begin
                    err_flag <= 1'b0;
                end
            end

            // a new error wins over a clear in the same cycle
            if (error_pulse) begin
                err_flag <= 1'b1;
            end

            if (exec_write && op.index >= IDX_SCRATCH0) begin
                scratch[op.index] <= merge_bytes(scratch[op.index], op.data, op.byte_en);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cpl_valid <= 1'b0;
        end else if (cpl_load) begin
            cpl_valid <= 1'b1;
        end else if (cpl_ready) begin
            cpl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl_load) begin
            cpl.tag <= op.tag;
            if (exec_read) begin
                cpl.status <= CPL_SC;
                cpl.data   <= rd_data;
            end else begin
                cpl.status <= CPL_UR;
                cpl.data   <= '0;
            end
        end
    end

    assign led_stat_g = led_g_en;
    assign led_stat_y = err_flag;

endmodule

/* src/activity_led.sv */
// Stretches single-cycle request pulses into a visible activity LED.

`timescale 1ns/1ps

module activity_led (
    input  logic clk,
    input  logic reset,
    input  logic req_accept,
    output logic led
);

    import pcie_core_pkg::*;

    logic [ACT_CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt <= '0;
        end else if (req_accept) begin
            // restart the hold on every request
            hold_cnt <= ACT_CNT_W'(ACT_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign led = (hold_cnt != '0);

endmodule

/* src/fpga_core.sv */
// Top level of the PCIe completer core.
// Request slice, BAR0 decoder, register file and completion slice in one path.

`timescale 1ns/1ps

module fpga_core (
    input  logic                   clk,
    input  logic                   reset,

    // completer requests
    input  logic                   cq_valid,
    output logic                   cq_ready,
    input  pcie_core_pkg::cq_req_t cq_req,

    // completions
    output logic                   cc_valid,
    input  logic                   cc_ready,
    output pcie_core_pkg::cc_cpl_t cc_cpl,

    output logic                   qsfp_led_act,
    output logic                   qsfp_led_stat_g,
    output logic                   qsfp_led_stat_y,
    output logic                   status_error_uncor
);

    import pcie_core_pkg::*;

    logic    req_valid;
    logic    req_ready;
    cq_req_t req;

    logic    op_valid;
    logic    op_ready;
    reg_op_t op;

    logic    cpl_valid;
    logic    cpl_ready;
    cc_cpl_t cpl;

    logic    req_accept;

    skid_buffer #(
        .payload_t(cq_req_t)
    ) cq_skid (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cq_valid),
        .in_ready  (cq_ready),
        .in_data   (cq_req),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req)
    );

    cq_decoder cq_decoder_inst (
        .clk                (clk),
        .reset              (reset),
        .in_valid           (req_valid),
        .in_ready           (req_ready),
        .in_req             (req),
        .op_valid           (op_valid),
        .op_ready           (op_ready),
        .op                 (op),
        .req_accept         (req_accept),
        .status_error_uncor (status_error_uncor)
    );

    bar_regfile bar_regfile_inst (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op          (op),
        .error_pulse (status_error_uncor),
        .cpl_valid   (cpl_valid),
        .cpl_ready   (cpl_ready),
        .cpl         (cpl),
        .led_stat_g  (qsfp_led_stat_g),
        .led_stat_y  (qsfp_led_stat_y)
    );

    skid_buffer #(
        .payload_t(cc_cpl_t)
    ) cc_skid (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cpl_valid),
        .in_ready  (cpl_ready),
        .in_data   (cpl),
        .out_valid (cc_valid),
        .out_ready (cc_ready),
        .out_data  (cc_cpl)
    );

    activity_led activity_led_inst (
        .clk        (clk),
        .reset      (reset),
        .req_accept (req_accept),
        .led        (qsfp_led_act)
    );

endmodule

/* verification/tb_fpga_core.sv */
// Self-checking testbench for the PCIe completer core.
// Directed register, miss and LED tests, then random traffic under completion back-pressure.
// Expected completions come from a register model and are compared in order.

`timescale 1ns/1ps

module tb_fpga_core;

    import pcie_core_pkg::*;

    localparam int N_DIRECTED      = 16;
    localparam int N_RANDOM        = 300;
    localparam int WATCHDOG_CYCLES = 20 * (N_DIRECTED + N_RANDOM) + ACT_HOLD;
    localparam int SETTLE_LIMIT    = 200;

    logic    clk;
    logic    reset;
    logic    cq_valid;
    logic    cq_ready;
    cq_req_t cq_req;
    logic    cc_valid;
    logic    cc_ready;
    cc_cpl_t cc_cpl;
    logic    qsfp_led_act;
    logic    qsfp_led_stat_g;
    logic    qsfp_led_stat_y;
    logic    status_error_uncor;

    // register model state
    logic [DATA_W-1:0] model_regs [REG_COUNT];
    logic              model_led_g;
    logic              model_err;
    logic [DATA_W-1:0] model_count;
    cc_cpl_t           exp_q [$];

    logic [31:0] stim_state;
    logic [31:0] rdy_state;
    logic        bp_mode;
    logic        measure_latency;
    time         issue_time;
    int          err_pulses;
    int          cpl_errs;
    int          flag_errs;
    int          misc_errs;

    fpga_core fpga_core_inst (
        .clk                (clk),
        .reset              (reset),
        .cq_valid           (cq_valid),
        .cq_ready           (cq_ready),
        .cq_req             (cq_req),
        .cc_valid           (cc_valid),
        .cc_ready           (cc_ready),
        .cc_cpl             (cc_cpl),
        .qsfp_led_act       (qsfp_led_act),
        .qsfp_led_stat_g    (qsfp_led_stat_g),
        .qsfp_led_stat_y    (qsfp_led_stat_y),
        .status_error_uncor (status_error_uncor)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic cq_req_t make_req(
        input logic                 is_write,
        input logic [BAR_NUM_W-1:0] bar,
        input logic [DW_ADDR_W-1:0] dw_addr,
        input logic [TAG_W-1:0]     tag,
        input logic [BE_W-1:0]      byte_en,
        input logic [DATA_W-1:0]    data
    );
        cq_req_t r;
        r.is_write = is_write;
        r.bar      = bar;
        r.dw_addr  = dw_addr;
        r.tag      = tag;
        r.byte_en  = byte_en;
        r.data     = data;
        return r;
    endfunction

    // applies one request to the model in issue order and returns its completion
    function automatic cc_cpl_t model_request(input cq_req_t req, output bit has_cpl);
        cc_cpl_t res;
        logic    hit;
        int      idx;
        res     = '0;
        res.tag = req.tag;
        hit     = (req.bar == 0) && (req.dw_addr < REG_COUNT);
        idx     = req.dw_addr % REG_COUNT;
        has_cpl = !req.is_write;
        if (!hit) begin
            if (req.is_write) begin
                model_err = 1'b1;
            end
            res.status = CPL_UR;
        end else if (!req.is_write) begin
            res.status = CPL_SC;
            case (idx)
                0:       res.data = CORE_ID;
                1:       res.data = {29'd0, model_err, 1'b0, model_led_g};
                2:       res.data = model_count;
                default: res.data = model_regs[idx];
            endcase
            model_count = model_count + 1;
        end else begin
            if (idx == 1 && req.byte_en[0]) begin
                model_led_g = req.data[0];
                if (req.data[1]) begin
                    model_err = 1'b0;
                end
            end else if (idx >= 3) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.byte_en[b]) begin
                        model_regs[idx][8*b +: 8] = req.data[8*b +: 8];
                    end
                end
            end
            model_count = model_count + 1;
        end
        return res;
    endfunction

    task automatic check_cpl(input cc_cpl_t exp, input cc_cpl_t act);
        if (act !== exp) begin
            cpl_errs++;
            $display("ERR cc_cpl exp tag=%h status=%h data=%h got tag=%h status=%h data=%h",
                     exp.tag, exp.status, exp.data, act.tag, act.status, act.data);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("ERR %s exp %h got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            misc_errs++;
            $display("ERR %s exp %h got %h", name, exp, act);
        end
    endtask

    // starts right after a rising edge and returns at the handshake edge
    task automatic send_req(input cq_req_t r);
        bit      has_cpl;
        cc_cpl_t exp;
        cq_valid <= 1'b1;
        cq_req   <= r;
        @(negedge clk);
        while (!cq_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        issue_time = $time;
        exp = model_request(r, has_cpl);
        if (has_cpl) begin
            exp_q.push_back(exp);
        end
    endtask

    // wait for outstanding completions and for writes to land
    task automatic settle();
        int waited;
        cq_valid <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < SETTLE_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected completions never arrived", exp_q.size());
            misc_errs++;
            exp_q.delete();
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic check_leds(input logic exp_g, input logic exp_y);
        @(negedge clk);
        check_flag("qsfp_led_stat_g", exp_g, qsfp_led_stat_g);
        check_flag("qsfp_led_stat_y", exp_y, qsfp_led_stat_y);
        @(posedge clk);
    endtask

    task automatic random_traffic(input int count);
        logic [31:0] r;
        cq_req_t     req;
        for (int i = 0; i < count; i++) begin
            r            = next_random();
            req.is_write = r[0];
            req.bar      = (r[4:1] == 0) ? r[7:5] : 3'd0;
            req.dw_addr  = (r[10:8] == 0) ? r[18:11] : {4'd0, r[22:19]};
            req.tag      = 8'(i);
            req.byte_en  = r[26:23];
            req.data     = next_random();
            // occasional idle cycle on the request link
            if (r[31:29] == 0) begin
                cq_valid <= 1'b0;
                @(posedge clk);
            end
            send_req(req);
        end
    endtask

    // random completion ready only while back-pressure is on
    always @(posedge clk) begin
        if (bp_mode) begin
            rdy_state = xorshift32(rdy_state);
            cc_ready <= (rdy_state[1:0] != 2'd0);
        end else begin
            cc_ready <= 1'b1;
        end
    end

    // compares each completion in the cycle before its transfer edge
    always @(negedge clk) begin
        if (!reset && cc_valid && cc_ready) begin
            if (exp_q.size() == 0) begin
                $display("completion with tag %h arrived while none was expected", cc_cpl.tag);
                misc_errs++;
            end else begin
                check_cpl(exp_q.pop_front(), cc_cpl);
            end
            if (measure_latency) begin
                check_count("cc latency cycles", 4, int'(($time + 5 - issue_time) / 10));
                measure_latency = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && status_error_uncor) begin
            err_pulses++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int pulses_before;
        clk             = 1'b0;
        reset           = 1'b1;
        cq_valid        = 1'b0;
        cq_req          = '0;
        cc_ready        = 1'b1;
        bp_mode         = 1'b0;
        measure_latency = 1'b0;
        issue_time      = 0;
        err_pulses      = 0;
        cpl_errs        = 0;
        flag_errs       = 0;
        misc_errs       = 0;
        stim_state      = 32'd84800;
        rdy_state       = ~32'd84800;
        model_led_g     = 1'b0;
        model_err       = 1'b0;
        model_count     = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("cc_valid", 1'b0, cc_valid);
        check_flag("status_error_uncor", 1'b0, status_error_uncor);
        check_flag("qsfp_led_act", 1'b0, qsfp_led_act);
        check_flag("qsfp_led_stat_g", 1'b0, qsfp_led_stat_g);
        check_flag("qsfp_led_stat_y", 1'b0, qsfp_led_stat_y);
        @(posedge clk);

        // identifier read through an empty pipeline
        measure_latency = 1'b1;
        send_req(make_req(1'b0, 3'd0, 8'd0, 8'h11, 4'hf, '0));
        settle();

        // byte merges on scratch, writes to read-only indices
        send_req(make_req(1'b1, 3'd0, 8'd3, 8'h20, 4'hf, 32'h1122_3344));
        send_req(make_req(1'b1, 3'd0, 8'd3, 8'h21, 4'b0101, 32'haabb_ccdd));
        send_req(make_req(1'b1, 3'd0, 8'd15, 8'h22, 4'b1000, 32'hdead_beef));
        send_req(make_req(1'b1, 3'd0, 8'd0, 8'h23, 4'hf, 32'hffff_ffff));
        send_req(make_req(1'b1, 3'd0, 8'd2, 8'h24, 4'hf, 32'hffff_ffff));
        send_req(make_req(1'b0, 3'd0, 8'd3, 8'h25, 4'hf, '0));
        send_req(make_req(1'b0, 3'd0, 8'd15, 8'h26, 4'hf, '0));
        send_req(make_req(1'b0, 3'd0, 8'd0, 8'h27, 4'hf, '0));
        send_req(make_req(1'b0, 3'd0, 8'd2, 8'h28, 4'hf, '0));
        settle();

        // misses, sticky error and its clear
        send_req(make_req(1'b0, 3'd1, 8'd0, 8'h30, 4'hf, '0));
        send_req(make_req(1'b0, 3'd0, 8'd16, 8'h31, 4'hf, '0));
        pulses_before = err_pulses;
        send_req(make_req(1'b1, 3'd0, 8'd200, 8'h32, 4'hf, 32'h1234_5678));
        settle();
        check_count("status_error_uncor pulses", pulses_before + 1, err_pulses);
        check_leds(1'b0, 1'b1);
        send_req(make_req(1'b1, 3'd0, 8'd1, 8'h33, 4'h1, 32'h0000_0003));
        send_req(make_req(1'b0, 3'd0, 8'd1, 8'h34, 4'hf, '0));
        settle();
        check_leds(1'b1, 1'b0);

        // mixed traffic under back-pressure
        bp_mode <= 1'b1;
        random_traffic(N_RANDOM);
        settle();
        bp_mode <= 1'b0;
        check_leds(model_led_g, model_err);

        // activity LED hold and release
        send_req(make_req(1'b0, 3'd0, 8'd0, 8'h40, 4'hf, '0));
        settle();
        @(negedge clk);
        check_flag("qsfp_led_act", 1'b1, qsfp_led_act);
        repeat (ACT_HOLD + 8) @(posedge clk);
        @(negedge clk);
        check_flag("qsfp_led_act", 1'b0, qsfp_led_act);

        $display("error counts: completion %0d, flag %0d, other %0d",
                 cpl_errs, flag_errs, misc_errs);
        if (cpl_errs + flag_errs + misc_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/pcie_core_pkg.sv
src/skid_buffer.sv
src/cq_decoder.sv
src/bar_regfile.sv
src/activity_led.sv
src/fpga_core.sv
verification/tb_fpga_core.sv

/* Makefile */
# Verilator lint, simulation and clean targets for the PCIe completer core

TB  = tb_fpga_core
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module fpga_core

obj_dir/V$(TB): filelist.f src/*.sv verification/*.sv
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TB) -o V$(TB)

sim: obj_dir/V$(TB)
	./obj_dir/V$(TB) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
